// File: src/mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////
	// Instruction word views
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} j_fmt_t;

	// Same 32 bits, three decodings
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

	//////////////////////////////////////////////////
	// Control groups
	//////////////////////////////////////////////////

	typedef struct packed {
		logic       jal_link;  // Link into a register
		logic       jal_only;
		logic       reg_dst;   // Write rd instead of rt
		logic       alu_src1;  // Shamt as operand A
		logic       alu_src2;  // Immediate as operand B
		logic       jump;
		logic       jump_reg;
		logic [3:0] alu_code;
	} exec_ctrl_t;

	typedef struct packed {
		logic bne;
		logic sb;
		logic sh;
		logic lb;
		logic lh;
		logic unsign;   // Zero fill on narrow loads
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// Write-back port from the last stage
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} wb_port_t;

	typedef struct packed {
		exec_ctrl_t  exec;
		mem_ctrl_t   mem;
		wb_ctrl_t    wb;
		logic [31:0] rs_data;
		logic [31:0] rt_data;
		logic [31:0] imm_ext;
		logic [25:0] jump_index;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
	} id_ex_t;

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_LB    = 6'b100000;
	localparam logic [5:0] OP_LH    = 6'b100001;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_LWU   = 6'b100111;
	localparam logic [5:0] OP_LBU   = 6'b100100;
	localparam logic [5:0] OP_LHU   = 6'b100101;
	localparam logic [5:0] OP_SB    = 6'b101000;
	localparam logic [5:0] OP_SH    = 6'b101001;
	localparam logic [5:0] OP_SW    = 6'b101011;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;

	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;

	// ALU operation classes from the main decoder
	localparam logic [2:0] ALUOP_RTYPE = 3'b000;
	localparam logic [2:0] ALUOP_ADD   = 3'b001;
	localparam logic [2:0] ALUOP_AND   = 3'b010;
	localparam logic [2:0] ALUOP_OR    = 3'b011;
	localparam logic [2:0] ALUOP_XOR   = 3'b100;
	localparam logic [2:0] ALUOP_SLT   = 3'b110;
	localparam logic [2:0] ALUOP_LUI   = 3'b111;

	localparam logic [3:0] ALU_SLL = 4'd0;
	localparam logic [3:0] ALU_SRL = 4'd1;
	localparam logic [3:0] ALU_SRA = 4'd2;
	localparam logic [3:0] ALU_ADD = 4'd3;
	localparam logic [3:0] ALU_SUB = 4'd4;
	localparam logic [3:0] ALU_AND = 4'd5;
	localparam logic [3:0] ALU_OR  = 4'd6;
	localparam logic [3:0] ALU_XOR = 4'd7;
	localparam logic [3:0] ALU_NOR = 4'd8;
	localparam logic [3:0] ALU_SLT = 4'd9;
	localparam logic [3:0] ALU_LUI = 4'd10;

	localparam int REG_COUNT = 32;

endpackage

// File: src/control.sv
`timescale 1ns/1ps

module control (
	input  logic [5:0]           opcode,
	input  logic [5:0]           funct,
	output mips_pkg::exec_ctrl_t exec,
	output mips_pkg::mem_ctrl_t  mem,
	output mips_pkg::wb_ctrl_t   wb,
	output logic [2:0]           aluop
);

	always_comb
	begin
		// Everything off unless the opcode says otherwise
		exec  = '0;   // alu_code stays zero here
		mem   = '0;
		wb    = '0;
		aluop = mips_pkg::ALUOP_RTYPE;

		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				case (funct)
					mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA:
					begin
						exec.reg_dst  = 1'b1;
						exec.alu_src1 = 1'b1;   // Shift by shamt
						wb.reg_write  = 1'b1;
					end
					mips_pkg::FN_JR:
					begin
						exec.jump_reg = 1'b1;   // No register write
					end
					mips_pkg::FN_JALR:
					begin
						exec.jal_link = 1'b1;
						exec.reg_dst  = 1'b1;
						exec.jump_reg = 1'b1;
						wb.reg_write  = 1'b1;
					end
					default:
					begin
						exec.reg_dst = 1'b1;
						wb.reg_write = 1'b1;
					end
				endcase
			end

			//////////////////////////////////////////////////
			// Memory access
			//////////////////////////////////////////////////

			mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
			mips_pkg::OP_LWU, mips_pkg::OP_LBU, mips_pkg::OP_LHU:
			begin
				exec.alu_src2 = 1'b1;
				aluop         = mips_pkg::ALUOP_ADD;   // Base plus offset
				mem.mem_read  = 1'b1;
				mem.lb        = (opcode == mips_pkg::OP_LB) || (opcode == mips_pkg::OP_LBU);
				mem.lh        = (opcode == mips_pkg::OP_LH) || (opcode == mips_pkg::OP_LHU);
				mem.unsign    = (opcode == mips_pkg::OP_LBU) || (opcode == mips_pkg::OP_LHU);
				wb.reg_write  = 1'b1;
				wb.mem_to_reg = 1'b1;
			end
			mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW:
			begin
				exec.alu_src2 = 1'b1;
				aluop         = mips_pkg::ALUOP_ADD;
				mem.mem_write = 1'b1;
				mem.sb        = (opcode == mips_pkg::OP_SB);
				mem.sh        = (opcode == mips_pkg::OP_SH);
			end

			// Immediate arithmetic
			mips_pkg::OP_ADDI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
			mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_SLTI:
			begin
				exec.alu_src2 = 1'b1;
				wb.reg_write  = 1'b1;
				case (opcode)
					mips_pkg::OP_ANDI: aluop = mips_pkg::ALUOP_AND;
					mips_pkg::OP_ORI:  aluop = mips_pkg::ALUOP_OR;
					mips_pkg::OP_XORI: aluop = mips_pkg::ALUOP_XOR;
					mips_pkg::OP_LUI:  aluop = mips_pkg::ALUOP_LUI;
					mips_pkg::OP_SLTI: aluop = mips_pkg::ALUOP_SLT;
					default:           aluop = mips_pkg::ALUOP_ADD;
				endcase
			end

			//////////////////////////////////////////////////
			// Control flow
			//////////////////////////////////////////////////

			mips_pkg::OP_BEQ, mips_pkg::OP_BNE:
			begin
				aluop      = mips_pkg::ALUOP_SLT;   // Compare class for branches
				mem.branch = 1'b1;
				mem.bne    = (opcode == mips_pkg::OP_BNE);
			end
			mips_pkg::OP_J:
			begin
				exec.jump = 1'b1;
			end
			mips_pkg::OP_JAL:
			begin
				exec.jal_link = 1'b1;
				exec.jal_only = 1'b1;
				aluop         = mips_pkg::ALUOP_ADD;   // Return address
				wb.reg_write  = 1'b1;
			end
			default:
			begin
				aluop = mips_pkg::ALUOP_RTYPE;   // Unknown opcode decodes to nothing
			end
		endcase
	end

endmodule

// File: src/alu_control.sv
`timescale 1ns/1ps

module alu_control (
	input  logic [2:0] aluop,
	input  logic [5:0] funct,
	output logic [3:0] alu_code
);

	always_comb
	begin
		case (aluop)
			mips_pkg::ALUOP_RTYPE:
			begin
				// R-type picks the operation from the function field
				case (funct)
					mips_pkg::FN_SLL:  alu_code = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL:  alu_code = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA:  alu_code = mips_pkg::ALU_SRA;
					mips_pkg::FN_ADDU: alu_code = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: alu_code = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_code = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_code = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  alu_code = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  alu_code = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT:  alu_code = mips_pkg::ALU_SLT;
					default:           alu_code = mips_pkg::ALU_ADD;   // JR, JALR and the rest
				endcase
			end
			mips_pkg::ALUOP_ADD:
			begin
				alu_code = mips_pkg::ALU_ADD;
			end
			mips_pkg::ALUOP_AND: alu_code = mips_pkg::ALU_AND;
			mips_pkg::ALUOP_OR:  alu_code = mips_pkg::ALU_OR;
			mips_pkg::ALUOP_XOR: alu_code = mips_pkg::ALU_XOR;
			mips_pkg::ALUOP_SLT:
			begin
				alu_code = mips_pkg::ALU_SLT;   // Also used by BEQ and BNE
			end
			mips_pkg::ALUOP_LUI:
			begin
				alu_code = mips_pkg::ALU_LUI;
			end
			default:
			begin
				alu_code = mips_pkg::ALU_ADD;   // Unused class
			end
		endcase
	end

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic               clk,
	input  logic               reset,
	input  logic [4:0]         rs,
	input  logic [4:0]         rt,
	input  mips_pkg::wb_port_t wb,
	output logic [31:0]        rs_data,
	output logic [31:0]        rt_data
);

	logic [31:0] regs [mips_pkg::REG_COUNT];

	// Register 0 is never written
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < mips_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wb.we && (wb.addr != 5'd0))
		begin
			regs[wb.addr] <= wb.data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports with write-through
	//////////////////////////////////////////////////

	always_comb
	begin
		if (rs == 5'd0)
			rs_data = '0;
		else if (wb.we && (wb.addr == rs))
			rs_data = wb.data;   // Bypass same-cycle write
		else
			rs_data = regs[rs];

		if (rt == 5'd0)
			rt_data = '0;
		else if (wb.we && (wb.addr == rt))
			rt_data = wb.data;
		else
			rt_data = regs[rt];
	end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic               clk,
	input  logic               reset,
	input  mips_pkg::instr_t   instr,
	input  logic               instr_valid,
	input  logic               stall,
	input  mips_pkg::wb_port_t wb,
	output mips_pkg::id_ex_t   id_ex,
	output logic               id_ex_valid
);

	mips_pkg::exec_ctrl_t ctrl_exec;   // alu_code still zero
	mips_pkg::exec_ctrl_t exec_full;
	mips_pkg::mem_ctrl_t  ctrl_mem;
	mips_pkg::wb_ctrl_t   ctrl_wb;
	logic [2:0]           aluop;
	logic [3:0]           alu_code;
	logic [31:0]          rs_data;
	logic [31:0]          rt_data;
	logic [31:0]          imm_ext;
	logic                 zero_ext;
	mips_pkg::id_ex_t     id_ex_d;

	//////////////////////////////////////////////////
	// Decoders and register file
	//////////////////////////////////////////////////

	control u_control (
		.opcode (instr.r.opcode),
		.funct  (instr.r.funct),
		.exec   (ctrl_exec),
		.mem    (ctrl_mem),
		.wb     (ctrl_wb),
		.aluop  (aluop)
	);

	alu_control u_alu_control (
		.aluop    (aluop),
		.funct    (instr.r.funct),
		.alu_code (alu_code)
	);

	register_file u_register_file (
		.clk     (clk),
		.reset   (reset),
		.rs      (instr.r.rs),
		.rt      (instr.r.rt),
		.wb      (wb),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// Logical immediates are zero filled
	assign zero_ext = (instr.i.opcode == mips_pkg::OP_ANDI) ||
	                  (instr.i.opcode == mips_pkg::OP_ORI)  ||
	                  (instr.i.opcode == mips_pkg::OP_XORI);

	assign imm_ext = zero_ext ? {16'h0000, instr.i.imm}
	                          : {{16{instr.i.imm[15]}}, instr.i.imm};

	always_comb
	begin
		exec_full          = ctrl_exec;
		exec_full.alu_code = alu_code;
	end

	//////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////

	always_comb
	begin
		id_ex_d            = '0;
		id_ex_d.exec       = exec_full;
		id_ex_d.mem        = ctrl_mem;
		id_ex_d.wb         = ctrl_wb;
		id_ex_d.rs_data    = rs_data;
		id_ex_d.rt_data    = rt_data;
		id_ex_d.imm_ext    = imm_ext;
		id_ex_d.jump_index = instr.j.index;
		id_ex_d.rs         = instr.r.rs;
		id_ex_d.rt         = instr.r.rt;
		id_ex_d.rd         = instr.r.rd;
		if (!instr_valid)
		begin
			// Bubble, no side effects downstream
			id_ex_d.exec = '0;
			id_ex_d.mem  = '0;
			id_ex_d.wb   = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			id_ex       <= '0;
			id_ex_valid <= 1'b0;
		end
		else if (!stall)   // Hold everything while stalled
		begin
			id_ex       <= id_ex_d;
			id_ex_valid <= instr_valid;
		end
	end

endmodule

// File: verif/decode_stage_chk.sv
`timescale 1ns/1ps

module decode_stage_chk (
	input logic             clk,
	input logic             reset,
	input logic             stall,
	input mips_pkg::instr_t instr,
	input logic [31:0]      rs_data,
	input logic [31:0]      rt_data,
	input mips_pkg::id_ex_t id_ex,
	input logic             id_ex_valid
);

	// Bubble during reset and right after it
	reset_bubble: assert property (@(posedge clk) reset |=> !id_ex_valid)
		else $error("id_ex_valid high after a reset edge");

	stall_hold: assert property (@(posedge clk) disable iff (reset)
		stall |=> ($stable(id_ex) && $stable(id_ex_valid)))
		else $error("ID/EX register changed while stalled");

	//////////////////////////////////////////////////
	// Register 0 is hard-wired
	rs_zero: assert property (@(posedge clk) disable iff (reset)
		(instr.r.rs == 5'd0) |-> (rs_data == 32'd0))
		else $error("register 0 read back nonzero on rs");
	rt_zero: assert property (@(posedge clk) disable iff (reset)
		(instr.r.rt == 5'd0) |-> (rt_data == 32'd0))
		else $error("register 0 read back nonzero on rt");

endmodule

bind decode_stage decode_stage_chk u_decode_stage_chk (
	.clk         (clk),
	.reset       (reset),
	.stall       (stall),
	.instr       (instr),
	.rs_data     (rs_data),
	.rt_data     (rt_data),
	.id_ex       (id_ex),
	.id_ex_valid (id_ex_valid)
);

// File: verif/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

	logic               clk;
	logic               reset;
	mips_pkg::instr_t   instr;
	logic               instr_valid;
	logic               stall;
	mips_pkg::wb_port_t wb;
	mips_pkg::id_ex_t   id_ex;
	logic               id_ex_valid;

	logic [31:0] model [mips_pkg::REG_COUNT];   // Expected register contents
	logic [31:0] rng_state;

	// Stimulus table, one entry per index
	string       v_name [$];
	logic [31:0] v_word [$];
	int          v_stall [$];    // Stall cycles before acceptance
	logic        v_bypass [$];   // Same-cycle write-back to rs
	logic [10:0] v_exec [$];
	logic [8:0]  v_mem [$];
	logic [1:0]  v_wb [$];
	logic [31:0] v_imm [$];

	decode_stage u_decode_stage (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb          (wb),
		.id_ex       (id_ex),
		.id_ex_valid (id_ex_valid)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// rd is always 8 in R-type words
	function automatic logic [31:0] r_word(input int rs, input int rt, input int shamt,
		input logic [5:0] funct);
		return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], 5'd8, shamt[4:0], funct};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	task automatic check(input string name, input logic [158:0] expected,
		input logic [158:0] actual);
		if (actual !== expected)
		begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic wait_valid(input string name, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while ((id_ex_valid !== 1'b1) && (cycles < 20));
		if (id_ex_valid !== 1'b1)
		begin
			$display("id_ex_valid never went high for %s", name);
			$display("TEST FAILED");
			$fatal(1, "timeout waiting for id_ex_valid");
		end
	endtask

	task automatic add_vector(input string name, input logic [31:0] word, input int n_stall,
		input logic bypass, input logic [6:0] flags, input logic [3:0] alu_code,
		input logic [8:0] mem, input logic [1:0] wbc, input logic [31:0] imm);
		v_name.push_back(name);
		v_word.push_back(word);
		v_stall.push_back(n_stall);
		v_bypass.push_back(bypass);
		v_exec.push_back({flags, alu_code});
		v_mem.push_back(mem);
		v_wb.push_back(wbc);
		v_imm.push_back(imm);
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////

	// Flags: jal_link jal_only reg_dst alu_src1 alu_src2 jump jump_reg
	// Mem: bne sb sh lb lh unsign branch mem_read mem_write
	task automatic load_vectors();
		int i;
		for (i = 0; i < 16; i++)   // Fresh file, every register reads zero
			add_vector("zero_read", r_word(2 * i, 2 * i + 1, 0, mips_pkg::FN_ADDU), 0, 0,
				7'b0010000, mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004021);
		add_vector("sll", r_word(3, 4, 4, mips_pkg::FN_SLL), 0, 0, 7'b0011000,
			mips_pkg::ALU_SLL, 9'b0, 2'b10, 32'h00004100);
		add_vector("srl", r_word(5, 6, 4, mips_pkg::FN_SRL), 0, 0, 7'b0011000,
			mips_pkg::ALU_SRL, 9'b0, 2'b10, 32'h00004102);
		add_vector("sra", r_word(7, 8, 4, mips_pkg::FN_SRA), 0, 0, 7'b0011000,
			mips_pkg::ALU_SRA, 9'b0, 2'b10, 32'h00004103);
		add_vector("jr", r_word(31, 0, 0, mips_pkg::FN_JR), 0, 0, 7'b0000001,
			mips_pkg::ALU_ADD, 9'b0, 2'b00, 32'h00004008);
		add_vector("jalr", r_word(30, 0, 0, mips_pkg::FN_JALR), 0, 0, 7'b1010001,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004009);
		add_vector("addu", r_word(1, 2, 0, mips_pkg::FN_ADDU), 0, 0, 7'b0010000,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004021);
		add_vector("subu", r_word(9, 10, 0, mips_pkg::FN_SUBU), 0, 0, 7'b0010000,
			mips_pkg::ALU_SUB, 9'b0, 2'b10, 32'h00004023);
		add_vector("and", r_word(11, 12, 0, mips_pkg::FN_AND), 0, 0, 7'b0010000,
			mips_pkg::ALU_AND, 9'b0, 2'b10, 32'h00004024);
		add_vector("or", r_word(13, 14, 0, mips_pkg::FN_OR), 0, 0, 7'b0010000,
			mips_pkg::ALU_OR, 9'b0, 2'b10, 32'h00004025);
		add_vector("xor", r_word(15, 16, 0, mips_pkg::FN_XOR), 0, 0, 7'b0010000,
			mips_pkg::ALU_XOR, 9'b0, 2'b10, 32'h00004026);
		add_vector("nor", r_word(17, 18, 0, mips_pkg::FN_NOR), 0, 0, 7'b0010000,
			mips_pkg::ALU_NOR, 9'b0, 2'b10, 32'h00004027);
		add_vector("slt", r_word(19, 20, 0, mips_pkg::FN_SLT), 0, 0, 7'b0010000,
			mips_pkg::ALU_SLT, 9'b0, 2'b10, 32'h0000402a);
		add_vector("funct_other", r_word(21, 22, 0, 6'h18), 0, 0, 7'b0010000,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004018);
		add_vector("r0_read", r_word(0, 23, 0, mips_pkg::FN_ADDU), 0, 0, 7'b0010000,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004021);
		add_vector("addu_bypass", r_word(24, 25, 0, mips_pkg::FN_ADDU), 0, 1, 7'b0010000,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004021);
		add_vector("addu_stall", r_word(26, 27, 0, mips_pkg::FN_ADDU), 3, 0, 7'b0010000,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'h00004021);
		add_vector("lb", i_word(mips_pkg::OP_LB, 1, 2, 16'hfff0), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000100010, 2'b11, 32'hfffffff0);
		add_vector("lh", i_word(mips_pkg::OP_LH, 3, 4, 16'h0004), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000010010, 2'b11, 32'h00000004);
		add_vector("lw", i_word(mips_pkg::OP_LW, 5, 6, 16'h7ffc), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000000010, 2'b11, 32'h00007ffc);
		add_vector("lwu", i_word(mips_pkg::OP_LWU, 7, 8, 16'h8000), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000000010, 2'b11, 32'hffff8000);
		add_vector("lbu", i_word(mips_pkg::OP_LBU, 9, 10, 16'hff80), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000101010, 2'b11, 32'hffffff80);
		add_vector("lhu", i_word(mips_pkg::OP_LHU, 11, 12, 16'h0010), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000011010, 2'b11, 32'h00000010);
		add_vector("sb", i_word(mips_pkg::OP_SB, 13, 14, 16'hfffc), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b010000001, 2'b00, 32'hfffffffc);
		add_vector("sh", i_word(mips_pkg::OP_SH, 15, 16, 16'h0002), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b001000001, 2'b00, 32'h00000002);
		add_vector("sw", i_word(mips_pkg::OP_SW, 17, 18, 16'h8004), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b000000001, 2'b00, 32'hffff8004);
		add_vector("addi", i_word(mips_pkg::OP_ADDI, 21, 22, 16'hff00), 0, 0, 7'b0000100,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'hffffff00);
		add_vector("andi", i_word(mips_pkg::OP_ANDI, 23, 24, 16'hff00), 0, 0, 7'b0000100,
			mips_pkg::ALU_AND, 9'b0, 2'b10, 32'h0000ff00);
		add_vector("ori", i_word(mips_pkg::OP_ORI, 25, 26, 16'h8001), 0, 0, 7'b0000100,
			mips_pkg::ALU_OR, 9'b0, 2'b10, 32'h00008001);
		add_vector("xori", i_word(mips_pkg::OP_XORI, 27, 28, 16'hf0f0), 0, 0, 7'b0000100,
			mips_pkg::ALU_XOR, 9'b0, 2'b10, 32'h0000f0f0);
		add_vector("lui", i_word(mips_pkg::OP_LUI, 29, 30, 16'h1234), 0, 0, 7'b0000100,
			mips_pkg::ALU_LUI, 9'b0, 2'b10, 32'h00001234);
		add_vector("slti", i_word(mips_pkg::OP_SLTI, 31, 1, 16'hffff), 0, 0, 7'b0000100,
			mips_pkg::ALU_SLT, 9'b0, 2'b10, 32'hffffffff);
		add_vector("beq", i_word(mips_pkg::OP_BEQ, 2, 3, 16'h0010), 0, 0, 7'b0000000,
			mips_pkg::ALU_SLT, 9'b000000100, 2'b00, 32'h00000010);
		add_vector("bne", i_word(mips_pkg::OP_BNE, 4, 5, 16'hfffe), 0, 0, 7'b0000000,
			mips_pkg::ALU_SLT, 9'b100000100, 2'b00, 32'hfffffffe);
		// J funct bits are index[5:0], zero here so the code is SLL
		add_vector("j", {mips_pkg::OP_J, 26'h00001c0}, 0, 0, 7'b0000010,
			mips_pkg::ALU_SLL, 9'b0, 2'b00, 32'h000001c0);
		add_vector("jal", {mips_pkg::OP_JAL, 26'h3ff8000}, 0, 0, 7'b1100000,
			mips_pkg::ALU_ADD, 9'b0, 2'b10, 32'hffff8000);
		add_vector("unknown", i_word(6'b111111, 1, 2, 16'h0040), 0, 0, 7'b0000000,
			mips_pkg::ALU_SLL, 9'b0, 2'b00, 32'h00000040);
	endtask

	//////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////

	task automatic preload_registers();
		int r;
		for (r = 0; r < mips_pkg::REG_COUNT; r++)
		begin
			rng_state = xorshift32(rng_state);
			@(posedge clk);
			wb.we   <= 1'b1;
			wb.addr <= r[4:0];
			wb.data <= rng_state;
			if (r != 0)
				model[r] = rng_state;   // Register 0 keeps zero
		end
		@(posedge clk);
		wb.we <= 1'b0;
	endtask

	task automatic apply_vector(input int n);
		mips_pkg::instr_t w;
		mips_pkg::id_ex_t held;
		int               k;
		int               lat;
		w = v_word[n];
		@(posedge clk);
		instr       <= w;
		instr_valid <= 1'b1;
		stall       <= (v_stall[n] > 0);
		if (v_bypass[n])
		begin
			rng_state = xorshift32(rng_state);
			wb.we   <= 1'b1;
			wb.addr <= w.r.rs;
			wb.data <= rng_state;
			if (w.r.rs != 5'd0)
				model[w.r.rs] = rng_state;
		end
		if (v_stall[n] > 0)
		begin
			@(negedge clk);
			held = id_ex;
			for (k = 0; k < v_stall[n]; k++)
			begin
				@(posedge clk);
				if (k == v_stall[n] - 1)
					stall <= 1'b0;
				@(negedge clk);
				check({v_name[n], " held"}, held, id_ex);
				check({v_name[n], " held valid"}, 1'b0, id_ex_valid);
			end
		end
		@(posedge clk);   // Taken here
		instr_valid <= 1'b0;
		wb.we       <= 1'b0;
		wait_valid(v_name[n], lat);
		check({v_name[n], " latency"}, 1, lat);   // One cycle from acceptance
		check({v_name[n], " exec"}, v_exec[n], id_ex.exec);
		check({v_name[n], " mem"}, v_mem[n], id_ex.mem);
		check({v_name[n], " wb"}, v_wb[n], id_ex.wb);
		check({v_name[n], " imm"}, v_imm[n], id_ex.imm_ext);
		check({v_name[n], " rs_data"}, model[w.r.rs], id_ex.rs_data);
		check({v_name[n], " rt_data"}, model[w.r.rt], id_ex.rt_data);
		check({v_name[n], " fields"}, {w.r.rs, w.r.rt, w.r.rd, w.j.index},
			{id_ex.rs, id_ex.rt, id_ex.rd, id_ex.jump_index});
	endtask

	initial
	begin
		int i;
		clk         = 1'b0;
		reset       = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		stall       = 1'b0;
		wb          = '0;
		rng_state   = 32'h81ea;
		for (i = 0; i < mips_pkg::REG_COUNT; i++)
			model[i] = 32'd0;
		load_vectors();

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("reset valid", 1'b0, id_ex_valid);
		check("reset exec", 11'd0, id_ex.exec);
		check("reset mem", 9'd0, id_ex.mem);
		check("reset wb", 2'd0, id_ex.wb);

		// Zero reads first, then the preloaded file
		for (i = 0; i < 16; i++)
			apply_vector(i);
		preload_registers();
		for (i = 16; i < v_word.size(); i++)
			apply_vector(i);

		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: tb.f
src/mips_pkg.sv
src/control.sv
src/alu_control.sv
src/register_file.sv
src/decode_stage.sv
verif/decode_stage_chk.sv
verif/tb_decode_stage.sv
